/* hdl/imul_pkg.sv */
// shared types for the iterative signed multiplier
// state encoding of the control FSM and the control strobes it sends out

package imul_pkg;

  // ----------------------------------------
  // control FSM states
  // ----------------------------------------

  // IDLE waits for a request, CALC runs the shift-add steps,
  // DONE presents the product until the response handshake
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } imul_state_e;

  // ----------------------------------------
  // control strobes to the data modules
  // ----------------------------------------

  // one bundle goes to the counter, operand prep and shift-add blocks
  typedef struct packed {
    // capture operands, clear accumulator, preset counter
    logic load;
    // one shift-add iteration, counter decrements
    logic step;
    // output the negated accumulator
    logic negate;
  } imul_ctrl_t;

endpackage

/* hdl/imul_cycle_counter.sv */
// iteration counter for the shift-add multiplier
// counts down from op_width-1 and flags the final iteration

module imul_cycle_counter
  import imul_pkg::*;
#(
  parameter int op_width = 32
) (
  input  logic       clk,
  input  logic       reset,
  input  imul_ctrl_t ctrl,
  output logic       last_iter
);

  // enough bits to hold op_width-1
  localparam int cnt_w = $clog2(op_width);

  logic [cnt_w-1:0] count;

  // preset on load, count down on each step
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
    end else if (ctrl.load) begin
      count <= cnt_w'(op_width - 1);
    end else if (ctrl.step) begin
      count <= count - cnt_w'(1);
    end
  end

  // the step taken while the count is zero is the last one
  assign last_iter = (count == '0);

  // load only comes from IDLE and step only from CALC
  a_no_load_and_step: assert property (
    @(posedge clk) disable iff (reset) !(ctrl.load && ctrl.step)
  );

  // the FSM must leave CALC after the last step, so no wrap to all ones
  a_no_step_past_zero: assert property (
    @(posedge clk) disable iff (reset) (ctrl.step && last_iter) |=> !ctrl.step
  );

endmodule

/* hdl/imul_ctrl_fsm.sv */
// control FSM of the iterative multiplier
// runs the val/rdy handshakes and steers the data modules through ctrl

module imul_ctrl_fsm
  import imul_pkg::*;
(
  input  logic       clk,
  input  logic       reset,

  // request side
  input  logic       req_val,
  output logic       req_rdy,

  // response side
  output logic       resp_val,
  input  logic       resp_rdy,

  // status from the data modules
  input  logic       last_iter,
  input  logic       prod_sign,

  // strobes to the data modules
  output imul_ctrl_t ctrl
);

  imul_state_e state;
  imul_state_e state_next;

  logic req_go;
  logic resp_go;

  // ----------------------------------------
  // handshake
  // ----------------------------------------

  // one request in flight, so ready only when idle
  assign req_rdy  = (state == IDLE);
  assign resp_val = (state == DONE);

  // transfers on both sides
  assign req_go  = req_val && req_rdy;
  assign resp_go = resp_val && resp_rdy;

  // ----------------------------------------
  // state register and next state
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (req_go) begin
          state_next = CALC;
        end
      end
      CALC: begin
        // leave after the step with count zero
        if (last_iter) begin
          state_next = DONE;
        end
      end
      DONE: begin
        // hold the product until the consumer takes it
        if (resp_go) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  // ----------------------------------------
  // control strobes
  // ----------------------------------------

  // load on the accepting cycle, step through all of CALC
  assign ctrl.load   = req_go;
  assign ctrl.step   = (state == CALC);
  // product sign was captured with the operands
  assign ctrl.negate = (state == DONE) && prod_sign;

  a_rdy_val_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(resp_val && req_rdy)
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (reset) state inside {IDLE, CALC, DONE}
  );

endmodule

/* hdl/imul_operand_prep.sv */
// operand preparation for the signed multiplier
// strips the operand signs and keeps the product sign for the output stage

module imul_operand_prep
  import imul_pkg::*;
#(
  parameter int op_width = 32
) (
  input  logic                clk,
  input  logic                reset,
  input  imul_ctrl_t          ctrl,
  input  logic [op_width-1:0] req_a,
  input  logic [op_width-1:0] req_b,
  output logic [op_width-1:0] mag_a,
  output logic [op_width-1:0] mag_b,
  output logic                prod_sign
);

  logic sign_a;
  logic sign_b;

  assign sign_a = req_a[op_width-1];
  assign sign_b = req_b[op_width-1];

  // ----------------------------------------
  // magnitudes
  // ----------------------------------------

  // two's-complement negate when the sign bit is set;
  // the most negative value maps onto itself, which reads
  // correctly as an unsigned magnitude
  assign mag_a = sign_a ? (~req_a + 1'b1) : req_a;
  assign mag_b = sign_b ? (~req_b + 1'b1) : req_b;

  // ----------------------------------------
  // product sign
  // ----------------------------------------

  // operands are only valid on the accepting cycle, so latch here
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_sign <= 1'b0;
    end else if (ctrl.load) begin
      prod_sign <= sign_a ^ sign_b;
    end
  end

endmodule

/* hdl/imul_shift_add.sv */
// shift-add datapath of the iterative multiplier
// one partial product per step, with sign restore on the output

module imul_shift_add
  import imul_pkg::*;
#(
  parameter int op_width = 32
) (
  input  logic                  clk,
  input  logic                  reset,
  input  imul_ctrl_t            ctrl,
  input  logic [op_width-1:0]   mag_a,
  input  logic [op_width-1:0]   mag_b,
  output logic [2*op_width-1:0] resp_result
);

  // multiplicand, widened so it can shift left by op_width places
  logic [2*op_width-1:0] a_reg;
  // multiplier, consumed from the low end
  logic [op_width-1:0]   b_reg;
  // running sum of partial products
  logic [2*op_width-1:0] acc;

  logic [2*op_width-1:0] acc_sum;

  // ----------------------------------------
  // operand shift registers
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      // zero-extend the magnitude into the wide register
      a_reg <= {{op_width{1'b0}}, mag_a};
      b_reg <= mag_b;
    end else if (ctrl.step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // ----------------------------------------
  // accumulator
  // ----------------------------------------

  // partial product is a_reg or nothing, picked by the current multiplier bit
  assign acc_sum = b_reg[0] ? (acc + a_reg) : acc;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (ctrl.load) begin
      acc <= '0;
    end else if (ctrl.step) begin
      acc <= acc_sum;
    end
  end

  // ----------------------------------------
  // output
  // ----------------------------------------

  // acc holds the unsigned product after the last step;
  // negate it back when exactly one operand was negative
  assign resp_result = ctrl.negate ? (~acc + 1'b1) : acc;

endmodule

/* hdl/imul_iterative.sv */
// iterative signed integer multiplier, top level
// val/rdy request of two operands, double-width signed product after op_width steps

module imul_iterative
  import imul_pkg::*;
#(
  parameter int op_width = 32
) (
  input  logic                  clk,
  input  logic                  reset,

  input  logic [op_width-1:0]   req_a,
  input  logic [op_width-1:0]   req_b,
  input  logic                  req_val,
  output logic                  req_rdy,

  output logic [2*op_width-1:0] resp_result,
  output logic                  resp_val,
  input  logic                  resp_rdy
);

  imul_ctrl_t          ctrl;
  logic                last_iter;
  logic                prod_sign;
  logic [op_width-1:0] mag_a;
  logic [op_width-1:0] mag_b;

  // handshake and sequencing
  imul_ctrl_fsm u_ctrl_fsm (
    .clk       (clk),
    .reset     (reset),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .last_iter (last_iter),
    .prod_sign (prod_sign),
    .ctrl      (ctrl)
  );

  // counts the shift-add steps
  imul_cycle_counter #(.op_width(op_width)) u_cycle_counter (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .last_iter (last_iter)
  );

  // sign removal and product sign
  imul_operand_prep #(.op_width(op_width)) u_operand_prep (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .req_a     (req_a),
    .req_b     (req_b),
    .mag_a     (mag_a),
    .mag_b     (mag_b),
    .prod_sign (prod_sign)
  );

  // shift registers, accumulator and sign restore
  imul_shift_add #(.op_width(op_width)) u_shift_add (
    .clk         (clk),
    .reset       (reset),
    .ctrl        (ctrl),
    .mag_a       (mag_a),
    .mag_b       (mag_b),
    .resp_result (resp_result)
  );

endmodule

/* tests/imul_iterative_tb.sv */
// testbench for the iterative signed multiplier
// replays vectors from a data file and checks products, latency, busy and back-pressure

module imul_iterative_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int op_width = 32;
  localparam int clk_period = 20;
  localparam int reset_cycles = 10;
  // accept edge to first edge with resp_val high
  localparam int expected_latency = 33;

  logic                  clk;
  logic                  reset;
  logic [op_width-1:0]   req_a;
  logic [op_width-1:0]   req_b;
  logic                  req_val;
  logic                  req_rdy;
  logic [2*op_width-1:0] resp_result;
  logic                  resp_val;
  logic                  resp_rdy;

  // vectors from the data file
  logic [op_width-1:0]   vec_a[$];
  logic [op_width-1:0]   vec_b[$];
  logic [2*op_width-1:0] vec_prod[$];
  int                    vec_hold[$];

  int     error_count;
  int     check_count;
  int     max_hold;
  int     seed_init;
  int     gap;
  bit     vectors_loaded;
  longint watchdog_ns;

  imul_iterative #(.op_width(op_width)) dut (
    .clk         (clk),
    .reset       (reset),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #(clk_period / 2) clk = ~clk;

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  task automatic check_value(input string name, input logic [63:0] observed,
                             input logic [63:0] expected);
    check_count++;
    if (observed !== expected) begin
      error_count++;
      $display("Error at %0d ns: %s = 0x%h, expected 0x%h", $time, name, observed, expected);
    end
  endtask

  // lines starting with # are comments, blank lines are skipped
  task automatic load_vectors;
    int                    fd;
    int                    n;
    int                    h;
    string                 line;
    logic [op_width-1:0]   a;
    logic [op_width-1:0]   b;
    logic [2*op_width-1:0] p;
    fd = $fopen("tests/imul_input.txt", "r");
    if (fd == 0) begin
      error_count++;
      $display("could not open the vector file tests/imul_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %d", a, b, p, h);
      if (n == 4) begin
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_prod.push_back(p);
        vec_hold.push_back(h);
      end
    end
    $fclose(fd);
  endtask

  // outputs sampled on falling edges, away from the DUT's rising-edge updates
  task automatic apply_reset;
    repeat (reset_cycles - 1) begin
      @(negedge clk);
      check_value("resp_val", resp_val, 0);
      check_value("req_rdy", req_rdy, 1);
    end
    @(posedge clk);
    reset <= 1'b0;
    // first cycle out of reset
    @(negedge clk);
    check_value("resp_val", resp_val, 0);
    check_value("req_rdy", req_rdy, 1);
  endtask

  // one full request / response exchange
  task automatic run_vector(input logic [op_width-1:0] a, input logic [op_width-1:0] b,
                            input logic [2*op_width-1:0] prod, input int hold);
    int                    edges;
    int                    i;
    logic [2*op_width-1:0] first_result;
    @(posedge clk);
    req_a   <= a;
    req_b   <= b;
    req_val <= 1'b1;
    @(negedge clk);
    while (!req_rdy) begin
      @(negedge clk);
    end
    // accepting edge E0
    @(posedge clk);
    // keep req_val up with other operands while busy
    req_a <= ~a;
    req_b <= b + 32'h1357;
    edges = 1;
    @(negedge clk);
    // each falling edge shows what the next rising edge sees
    while (!resp_val && edges < 4 * expected_latency) begin
      check_value("req_rdy", req_rdy, 0);
      edges++;
      @(negedge clk);
    end
    check_value("latency", edges, expected_latency);
    first_result = resp_result;
    @(posedge clk);
    // back-pressure, result must not move
    for (i = 0; i < hold; i++) begin
      @(negedge clk);
      check_value("resp_val", resp_val, 1);
      check_value("req_rdy", req_rdy, 0);
      check_value("resp_result", resp_result, first_result);
      @(posedge clk);
    end
    resp_rdy <= 1'b1;
    @(negedge clk);
    check_value("resp_val", resp_val, 1);
    check_value("req_rdy", req_rdy, 0);
    check_value("resp_result", resp_result, prod);
    // transfer edge
    @(posedge clk);
    req_val  <= 1'b0;
    resp_rdy <= 1'b0;
    @(negedge clk);
    check_value("resp_val", resp_val, 0);
    check_value("req_rdy", req_rdy, 1);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin
    clk            = 1'b0;
    reset          = 1'b1;
    req_a          = '0;
    req_b          = '0;
    req_val        = 1'b0;
    resp_rdy       = 1'b0;
    error_count    = 0;
    check_count    = 0;
    max_hold       = 0;
    vectors_loaded = 1'b0;
    seed_init      = $urandom(32'h1457d97f);
    load_vectors();
    foreach (vec_hold[k]) begin
      if (vec_hold[k] > max_hold) begin
        max_hold = vec_hold[k];
      end
    end
    vectors_loaded = 1'b1;
    if (vec_a.size() == 0) begin
      error_count++;
      $display("no test vectors were loaded");
    end
    apply_reset();
    foreach (vec_a[k]) begin
      run_vector(vec_a[k], vec_b[k], vec_prod[k], vec_hold[k]);
      // idle gap of 0 to 3 cycles
      gap = $urandom_range(3, 0);
      repeat (gap) @(posedge clk);
    end
    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // watchdog, sized from the vector count and the longest hold
  initial begin
    wait (vectors_loaded);
    watchdog_ns = (longint'(vec_a.size()) * (40 + max_hold + 3) + reset_cycles) * clk_period;
    #(watchdog_ns);
    $display("watchdog expired: the test did not finish within %0d ns", watchdog_ns);
    $display("%0d checks, %0d errors", check_count, error_count);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* tests/imul_input.txt */
# columns: operand a (hex), operand b (hex), expected signed 64-bit product (hex),
# back-pressure hold count in cycles (decimal)
00000000 00000000 0000000000000000 0
00000001 00000001 0000000000000001 1
00000003 00000005 000000000000000f 0
00000007 fffffffd ffffffffffffffeb 2
fffffff9 00000003 ffffffffffffffeb 0
fffffffa fffffff9 000000000000002a 3
ffffffff ffffffff 0000000000000001 1
80000000 80000000 4000000000000000 5
80000000 ffffffff 0000000080000000 0
ffffffff 80000000 0000000080000000 2
7fffffff 7fffffff 3fffffff00000001 0
7fffffff 80000000 c000000080000000 4
80000000 00000001 ffffffff80000000 1
00000000 80000000 0000000000000000 0
ffffffff 00000000 0000000000000000 3
00000000 ffffffff 0000000000000000 0
ffffffff 00000001 ffffffffffffffff 7
00010000 00010000 0000000100000000 0
ffff0000 00010000 ffffffff00000000 2
12345678 00000010 0000000123456780 0
0000ffff 0000ffff 00000000fffe0001 1
fffffffe 40000000 ffffffff80000000 0
7fffffff ffffffff ffffffff80000001 6
00000064 ffffff9c ffffffffffffd8f0 0
ffffff9c ffffff9c 0000000000002710 2
00001000 00001000 0000000001000000 0
000003e8 000f4240 000000003b9aca00 1
fffffc18 000f4240 ffffffffc4653600 0
55555555 00000003 00000000ffffffff 3
aaaaaaab 00000003 ffffffff00000001 0
80000001 80000001 3fffffff00000001 2
deadbeef 00000002 ffffffffbd5b7dde 0
00000010 00000010 0000000000000100 1
7fffffff 00000002 00000000fffffffe 0
ffffffff 7fffffff ffffffff80000001 4

/* files.f */
hdl/imul_pkg.sv
hdl/imul_cycle_counter.sv
hdl/imul_ctrl_fsm.sv
hdl/imul_operand_prep.sv
hdl/imul_shift_add.sv
hdl/imul_iterative.sv
tests/imul_iterative_tb.sv

/* Bender.yml */
package:
  name: imul_iterative

sources:
  - hdl/imul_pkg.sv
  - hdl/imul_cycle_counter.sv
  - hdl/imul_ctrl_fsm.sv
  - hdl/imul_operand_prep.sv
  - hdl/imul_shift_add.sv
  - hdl/imul_iterative.sv
  - target: test
    files:
      - tests/imul_iterative_tb.sv
